/* common/nx4_pkg.sv */
package nx4_pkg;

    ////////////////////////////////////////////////////////////
    // external memory bus
    ////////////////////////////////////////////////////////////

    // shared flash / sram data pins, byte wide
    localparam int data_w = 8;

    // byte address as issued by the command side
    localparam int cmd_addr_w = 16;

    // paged upper address bits, held in a register field
    localparam int upper_addr_w = 5;

    // physical address pins, flash needs all 21
    localparam int ext_addr_w = 21;

    ////////////////////////////////////////////////////////////
    // board status and clocking
    ////////////////////////////////////////////////////////////

    // cpld pins + ry/by + xerr + sda sense
    localparam int status_w = 12;

    // pins sensed on the driver-board cpld
    localparam int cpld_pins_w = 9;

    // free-running divider, taps feed pixel and grayscale clocks
    localparam int div_count_w = 8;

    // select field picks one divider bit
    localparam int div_sel_w = 3;

    // first rise of this bit ends the power-up hold (1 << 3 clocks)
    localparam int reset_hold_bit = 3;

    ////////////////////////////////////////////////////////////
    // memory cycle timing
    ////////////////////////////////////////////////////////////

    // flash access is stretched, sram completes in one clock
    localparam int flash_cycle_len = 7;
    localparam int sram_cycle_len = 1;

    // flash we_n is released once the countdown reaches this value
    localparam int flash_we_rise = 2;

    // countdown must hold the longest cycle
    localparam int cycle_cnt_w = $clog2(flash_cycle_len + 1);

    typedef logic [cycle_cnt_w-1:0] cycle_cnt_t;

    // device addressed by the current or last cycle
    typedef enum logic {
        mem_flash,
        mem_sram
    } mem_target_e;

endpackage

/* hdl/nx4_board_ctl.sv */
`timescale 1ns/1ns

module nx4_board_ctl (
    input  logic                           clock,
    input  logic                           arst_n,

    // clock divider selects from the drive-control register
    input  logic [nx4_pkg::div_sel_w-1:0]   pclk_sel,
    input  logic [nx4_pkg::div_sel_w-1:0]   gclk_sel,

    // bit-banged i2c from the io-control register
    input  logic                           i2c_sda_ctl,
    input  logic                           i2c_scl_ctl,
    input  logic                           i2c_sda_in,

    // sensed board pins
    input  logic [nx4_pkg::cpld_pins_w-1:0] cpld_pins,
    input  logic                           flash_ry_by,
    input  logic                           led_xerr,

    output logic                           flash_reset_n,
    output logic                           pixel_clock,
    output logic                           grayscale_clock,
    output logic                           i2c_sda_low,
    output logic                           i2c_scl_low,
    output logic [nx4_pkg::status_w-1:0]    status
);

    // free-running divider count
    logic [nx4_pkg::div_count_w-1:0] div_count;

    ////////////////////////////////////////////////////////////
    // divider and power-up hold
    ////////////////////////////////////////////////////////////

    // counts from zero every clock, wraps freely
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // flash stays in reset until the hold bit first goes high
    // once released it never goes low again short of arst_n
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            flash_reset_n <= 1'b0;
        end else if (div_count[nx4_pkg::reset_hold_bit]) begin
            flash_reset_n <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // pixel and grayscale clock taps
    ////////////////////////////////////////////////////////////

    // bit n of the counter toggles every 2^n clocks
    // selects are live register fields, so the tap can move at run time
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pixel_clock     <= 1'b0;
            grayscale_clock <= 1'b0;
        end else begin
            pixel_clock     <= div_count[pclk_sel];
            grayscale_clock <= div_count[gclk_sel];
        end
    end

    ////////////////////////////////////////////////////////////
    // i2c open drain and status word
    ////////////////////////////////////////////////////////////

    // control bit set means release the line (pull-up wins)
    // control bit clear means pull the pin low
    assign i2c_sda_low = ~i2c_sda_ctl;
    assign i2c_scl_low = ~i2c_scl_ctl;

    // msb first: cpld pins, then ry/by, xerr, sda sense in bit 0
    assign status = {
        cpld_pins,
        flash_ry_by,
        led_xerr,
        i2c_sda_in
    };

endmodule

/* mem_bitbang/mem_cycle_sequencer.sv */
`timescale 1ns/1ns

module mem_cycle_sequencer (
    input  logic                            clock,
    input  logic                            arst_n,

    // command-side strobes, one clock each
    input  logic                            flash_op_req,
    input  logic                            sram_op_req,
    input  logic                            mem_write,
    input  logic [nx4_pkg::cmd_addr_w-1:0]   cmd_addr,
    input  logic [nx4_pkg::upper_addr_w-1:0] upper_addr,
    input  logic [nx4_pkg::data_w-1:0]       wr_data,
    output logic [nx4_pkg::data_w-1:0]       rd_data,

    // shared flash / sram pins
    output logic [nx4_pkg::ext_addr_w-1:0]   ext_addr,
    output logic [nx4_pkg::data_w-1:0]       data_out,
    output logic                            data_oe,
    input  logic [nx4_pkg::data_w-1:0]       data_in,
    output logic                            mem_we_n,
    output logic                            flash_ce_n,
    output logic                            flash_oe_n,
    output logic                            sram_ce_n,
    output logic                            sram_oe_n,
    output logic                            sram_bhe_n,
    output logic                            sram_ble_n
);

    // device of the running cycle
    nx4_pkg::mem_target_e target;

    // clocks left in the cycle, zero when idle
    nx4_pkg::cycle_cnt_t  countdown;

    logic cycle_active;
    logic last_cycle;
    logic we_window;

    ////////////////////////////////////////////////////////////
    // cycle countdown
    ////////////////////////////////////////////////////////////

    // no arbitration here; a strobe mid-cycle simply restarts it
    // flash wins when both strobes land together
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            target    <= nx4_pkg::mem_flash;
            countdown <= '0;
        end else if (flash_op_req) begin
            target    <= nx4_pkg::mem_flash;
            countdown <= nx4_pkg::cycle_cnt_t'(nx4_pkg::flash_cycle_len);
        end else if (sram_op_req) begin
            target    <= nx4_pkg::mem_sram;
            countdown <= nx4_pkg::cycle_cnt_t'(nx4_pkg::sram_cycle_len);
        end else if (cycle_active) begin
            countdown <= countdown - 1'b1;
        end
    end

    assign cycle_active = (countdown != '0);
    assign last_cycle   = (countdown == nx4_pkg::cycle_cnt_t'(1));

    ////////////////////////////////////////////////////////////
    // read capture
    ////////////////////////////////////////////////////////////

    // sample on the final active clock, valid once ce_n is back high
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (last_cycle && !mem_write) begin
            rd_data <= data_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobes and enables
    ////////////////////////////////////////////////////////////

    // flash: we_n low for countdown 7..3, released at 2 for data hold
    // sram: we_n low for the whole single-clock window
    always_comb begin
        if (target == nx4_pkg::mem_flash) begin
            we_window = (countdown > nx4_pkg::cycle_cnt_t'(nx4_pkg::flash_we_rise));
        end else begin
            we_window = cycle_active;
        end
    end

    assign mem_we_n = ~(mem_write && we_window);

    // chip enable only for the selected device while counting
    assign flash_ce_n = ~(cycle_active && (target == nx4_pkg::mem_flash));
    assign sram_ce_n  = ~(cycle_active && (target == nx4_pkg::mem_sram));

    // output enables are levels, held even between cycles
    assign flash_oe_n = ~((target == nx4_pkg::mem_flash) && !mem_write);
    assign sram_oe_n  = ~((target == nx4_pkg::mem_sram) && !mem_write);

    // drive the data pins only during a write window
    assign data_oe  = cycle_active && mem_write;
    assign data_out = data_oe ? wr_data : '0;

    ////////////////////////////////////////////////////////////
    // address pins
    ////////////////////////////////////////////////////////////

    // both parts are 16 bit wide used in byte mode
    // flash takes the byte address as is, sram drops bit 0 and
    // picks the byte lane with bhe/ble instead
    always_comb begin
        if (target == nx4_pkg::mem_flash) begin
            ext_addr = {upper_addr, cmd_addr};
        end else begin
            ext_addr = {1'b0, upper_addr, cmd_addr[nx4_pkg::cmd_addr_w-1:1]};
        end
    end

    // odd byte on the high lane
    assign sram_bhe_n = ~cmd_addr[0];
    assign sram_ble_n = cmd_addr[0];

endmodule

/* hdl/nx4_top.sv */
`timescale 1ns/1ns

module nx4_top (
    input  logic                            clock,
    input  logic                            arst_n,

    // board control fields and sensed pins
    input  logic [nx4_pkg::div_sel_w-1:0]    pclk_sel,
    input  logic [nx4_pkg::div_sel_w-1:0]    gclk_sel,
    input  logic                            i2c_sda_ctl,
    input  logic                            i2c_scl_ctl,
    input  logic                            i2c_sda_in,
    input  logic [nx4_pkg::cpld_pins_w-1:0]  cpld_pins,
    input  logic                            flash_ry_by,
    input  logic                            led_xerr,
    output logic                            flash_reset_n,
    output logic                            pixel_clock,
    output logic                            grayscale_clock,
    output logic                            i2c_sda_low,
    output logic                            i2c_scl_low,
    output logic [nx4_pkg::status_w-1:0]     status,

    // command side of the memory sequencer
    input  logic                            flash_op_req,
    input  logic                            sram_op_req,
    input  logic                            mem_write,
    input  logic [nx4_pkg::cmd_addr_w-1:0]   cmd_addr,
    input  logic [nx4_pkg::upper_addr_w-1:0] upper_addr,
    input  logic [nx4_pkg::data_w-1:0]       wr_data,
    output logic [nx4_pkg::data_w-1:0]       rd_data,

    // flash / sram pins, data bus split into in, out and enable
    output logic [nx4_pkg::ext_addr_w-1:0]   ext_addr,
    output logic [nx4_pkg::data_w-1:0]       data_out,
    output logic                            data_oe,
    input  logic [nx4_pkg::data_w-1:0]       data_in,
    output logic                            mem_we_n,
    output logic                            flash_ce_n,
    output logic                            flash_oe_n,
    output logic                            sram_ce_n,
    output logic                            sram_oe_n,
    output logic                            sram_bhe_n,
    output logic                            sram_ble_n
);

    ////////////////////////////////////////////////////////////
    // clocks, reset hold, i2c and status
    ////////////////////////////////////////////////////////////

    nx4_board_ctl u_board_ctl (
        .clock           (clock),
        .arst_n          (arst_n),
        .pclk_sel        (pclk_sel),
        .gclk_sel        (gclk_sel),
        .i2c_sda_ctl     (i2c_sda_ctl),
        .i2c_scl_ctl     (i2c_scl_ctl),
        .i2c_sda_in      (i2c_sda_in),
        .cpld_pins       (cpld_pins),
        .flash_ry_by     (flash_ry_by),
        .led_xerr        (led_xerr),
        .flash_reset_n   (flash_reset_n),
        .pixel_clock     (pixel_clock),
        .grayscale_clock (grayscale_clock),
        .i2c_sda_low     (i2c_sda_low),
        .i2c_scl_low     (i2c_scl_low),
        .status          (status)
    );

    ////////////////////////////////////////////////////////////
    // direct flash / sram access
    ////////////////////////////////////////////////////////////

    mem_cycle_sequencer u_mem_seq (
        .clock        (clock),
        .arst_n       (arst_n),
        .flash_op_req (flash_op_req),
        .sram_op_req  (sram_op_req),
        .mem_write    (mem_write),
        .cmd_addr     (cmd_addr),
        .upper_addr   (upper_addr),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .ext_addr     (ext_addr),
        .data_out     (data_out),
        .data_oe      (data_oe),
        .data_in      (data_in),
        .mem_we_n     (mem_we_n),
        .flash_ce_n   (flash_ce_n),
        .flash_oe_n   (flash_oe_n),
        .sram_ce_n    (sram_ce_n),
        .sram_oe_n    (sram_oe_n),
        .sram_bhe_n   (sram_bhe_n),
        .sram_ble_n   (sram_ble_n)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // reset held over 16 rising edges
    // released on a falling edge so no flop sees it change at its edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

/* sim/tb_nx4_top.sv */
`timescale 1ns/1ns

module tb_nx4_top;

    localparam int num_tests  = 5;
    localparam int wait_limit = 64;
    localparam int edge_limit = 300;

    logic clock;
    logic arst_n;
    logic [nx4_pkg::div_sel_w-1:0]    pclk_sel;
    logic [nx4_pkg::div_sel_w-1:0]    gclk_sel;
    logic                             i2c_sda_ctl;
    logic                             i2c_scl_ctl;
    logic                             i2c_sda_in;
    logic [nx4_pkg::cpld_pins_w-1:0]  cpld_pins;
    logic                             flash_ry_by;
    logic                             led_xerr;
    logic                             flash_reset_n;
    logic                             pixel_clock;
    logic                             grayscale_clock;
    logic                             i2c_sda_low;
    logic                             i2c_scl_low;
    logic [nx4_pkg::status_w-1:0]     status;
    logic                             flash_op_req;
    logic                             sram_op_req;
    logic                             mem_write;
    logic [nx4_pkg::cmd_addr_w-1:0]   cmd_addr;
    logic [nx4_pkg::upper_addr_w-1:0] upper_addr;
    logic [nx4_pkg::data_w-1:0]       wr_data;
    logic [nx4_pkg::data_w-1:0]       rd_data;
    logic [nx4_pkg::ext_addr_w-1:0]   ext_addr;
    logic [nx4_pkg::data_w-1:0]       data_out;
    logic                             data_oe;
    logic [nx4_pkg::data_w-1:0]       data_in = 8'h00;
    logic                             mem_we_n;
    logic                             flash_ce_n;
    logic                             flash_oe_n;
    logic                             sram_ce_n;
    logic                             sram_oe_n;
    logic                             sram_bhe_n;
    logic                             sram_ble_n;

    // run bookkeeping
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_mark = 0;
    logic [31:0] rng_state = 32'd16;

    // window seen by the bus monitor
    int win_len = 0;
    int win_we = 0;
    int seen_len = 0;
    int seen_we = 0;
    int cycles_seen = 0;
    nx4_pkg::mem_target_e win_target = nx4_pkg::mem_flash;
    logic [nx4_pkg::ext_addr_w-1:0] win_addr = '0;
    logic win_bhe_n = 1'b1;
    logic win_ble_n = 1'b1;

    // sparse external memories
    logic [7:0] flash_mem [logic [20:0]];
    logic [7:0] sram_mem [logic [21:0]];

    tb_clock_gen u_clock_gen (.clock(clock), .arst_n(arst_n));

    nx4_top dut0 (.*);

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand32();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // flash takes the upper bits then the byte address
    // sram takes the word address and the byte lane goes to bhe/ble
    function automatic logic [20:0] ref_addr(input nx4_pkg::mem_target_e t,
                                             input logic [15:0] a, input logic [4:0] up);
        if (t == nx4_pkg::mem_flash) begin
            return {up, a};
        end
        return {1'b0, up, a[15:1]};
    endfunction

    function automatic int ref_ce_len(input nx4_pkg::mem_target_e t);
        return (t == nx4_pkg::mem_flash) ? nx4_pkg::flash_cycle_len : nx4_pkg::sram_cycle_len;
    endfunction

    // flash we_n low for countdown 7 down to 3
    function automatic int ref_we_len(input nx4_pkg::mem_target_e t, input logic write);
        if (!write) begin
            return 0;
        end
        return (t == nx4_pkg::mem_flash) ? 5 : 1;
    endfunction

    // reads keep the last target's output enable low, writes keep both high
    function automatic logic ref_oe_n(input nx4_pkg::mem_target_e last,
                                      input nx4_pkg::mem_target_e dev, input logic write);
        if (write) begin
            return 1'b1;
        end
        return (last != dev);
    endfunction

    // hold bit goes high after 2^3 clocks and the release lands one clock later
    function automatic int ref_hold_clocks();
        return (1 << nx4_pkg::reset_hold_bit) + 1;
    endfunction

    function automatic logic [11:0] ref_status(input logic [8:0] pins, input logic ry,
                                               input logic xerr, input logic sda);
        return {pins, ry, xerr, sda};
    endfunction

    // unwritten bytes read back a pattern of the full address
    function automatic logic [7:0] fill_byte(input logic [21:0] a);
        return a[7:0] ^ a[15:8] ^ {2'b00, a[21:16]} ^ 8'ha5;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [20:0] a);
        if (flash_mem.exists(a)) begin
            return flash_mem[a];
        end
        return fill_byte({1'b0, a});
    endfunction

    function automatic logic [7:0] sram_byte(input logic [21:0] a);
        if (sram_mem.exists(a)) begin
            return sram_mem[a];
        end
        return fill_byte(a);
    endfunction

    function automatic logic tap_level(input logic gray);
        return gray ? grayscale_clock : pixel_clock;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic tally(input string name, input logic bad, input logic [31:0] got,
                         input logic [31:0] exp);
        checks++;
        if (bad) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input logic [nx4_pkg::ext_addr_w-1:0] got,
                              input logic [nx4_pkg::ext_addr_w-1:0] exp);
        tally(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic check_data(input string name, input logic [nx4_pkg::data_w-1:0] got,
                              input logic [nx4_pkg::data_w-1:0] exp);
        tally(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic check_status(input string name, input logic [nx4_pkg::status_w-1:0] got,
                                input logic [nx4_pkg::status_w-1:0] exp);
        tally(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic check_target(input string name, input nx4_pkg::mem_target_e got,
                                input nx4_pkg::mem_target_e exp);
        tally(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        tally(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic check_len(input string name, input int got, input int exp);
        tally(name, got != exp, 32'(got), 32'(exp));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // memory model and bus monitor
    ////////////////////////////////////////////////////////////

    // sampled mid-clock while the pins are settled
    always @(negedge clock) begin
        if (!mem_we_n && !flash_ce_n) begin
            flash_mem[ext_addr] = data_out;
        end
        if (!mem_we_n && !sram_ce_n) begin
            sram_mem[{ext_addr, ~sram_bhe_n}] = data_out;
        end
        if (!flash_ce_n) begin
            data_in <= flash_byte(ext_addr);
        end else if (!sram_ce_n) begin
            data_in <= sram_byte({ext_addr, ~sram_bhe_n});
        end else begin
            data_in <= 8'h00;
        end
    end

    // measures each chip-enable window and checks write data on the fly
    always @(negedge clock) begin
        if (!flash_ce_n || !sram_ce_n) begin
            if (win_len == 0) begin
                win_target = flash_ce_n ? nx4_pkg::mem_sram : nx4_pkg::mem_flash;
                win_addr = ext_addr;
                win_bhe_n = sram_bhe_n;
                win_ble_n = sram_ble_n;
            end
            win_len++;
            if (!mem_we_n) begin
                win_we++;
            end
            check_bit("data_oe", data_oe, mem_write);
            if (data_oe) begin
                check_data("data_out", data_out, wr_data);
            end
        end else if (win_len != 0) begin
            seen_len = win_len;
            seen_we = win_we;
            win_len = 0;
            win_we = 0;
            cycles_seen++;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // one strobe then a wait for the monitor to close the window
    task automatic run_cycle(input logic freq, input logic sreq, input logic write,
                             input logic [15:0] addr, input logic [4:0] up,
                             input logic [7:0] data, output logic [7:0] got_rd);
        nx4_pkg::mem_target_e t;
        int start;
        int waited;
        t = freq ? nx4_pkg::mem_flash : nx4_pkg::mem_sram;
        start = cycles_seen;
        waited = 0;
        @(posedge clock);
        flash_op_req <= freq;
        sram_op_req <= sreq;
        mem_write <= write;
        cmd_addr <= addr;
        upper_addr <= up;
        wr_data <= data;
        @(posedge clock);
        flash_op_req <= 1'b0;
        sram_op_req <= 1'b0;
        while (cycles_seen == start && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        @(negedge clock);
        got_rd = rd_data;
        if (cycles_seen == start) begin
            errors++;
            $display("memory cycle at 0x%0h never ended, chip enable stuck low", addr);
        end else begin
            check_target("chip enable target", win_target, t);
            check_len("chip enable low clocks", seen_len, ref_ce_len(t));
            check_len("mem_we_n low clocks", seen_we, ref_we_len(t, write));
            check_addr("ext_addr", win_addr, ref_addr(t, addr, up));
            if (t == nx4_pkg::mem_sram) begin
                check_bit("sram_bhe_n", win_bhe_n, ~addr[0]);
                check_bit("sram_ble_n", win_ble_n, addr[0]);
            end
            check_bit("data_oe", data_oe, 1'b0);
            check_bit("flash_oe_n", flash_oe_n, ref_oe_n(t, nx4_pkg::mem_flash, write));
            check_bit("sram_oe_n", sram_oe_n, ref_oe_n(t, nx4_pkg::mem_sram, write));
        end
    endtask

    // skip to a real edge of the tap then count clocks to the next one
    task automatic measure_half(input logic gray, output int half);
        logic prev;
        int n;
        int pass;
        n = 0;
        @(negedge clock);
        for (pass = 0; pass < 2; pass++) begin
            prev = tap_level(gray);
            n = 0;
            while (tap_level(gray) == prev && n < edge_limit) begin
                @(negedge clock);
                n++;
            end
        end
        half = n;
        if (n >= edge_limit) begin
            errors++;
            $display("no edge on %s within %0d clocks", gray ? "grayscale_clock" : "pixel_clock",
                     edge_limit);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [7:0] rd;
        int i;
        int half;
        int waited;
        {pclk_sel, gclk_sel, i2c_sda_ctl, i2c_scl_ctl, i2c_sda_in} = '0;
        {cpld_pins, flash_ry_by, led_xerr} = '0;
        {flash_op_req, sram_op_req, mem_write, cmd_addr, upper_addr, wr_data} = '0;

        // idle pins inside reset, then the power-up hold
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_bit("flash_ce_n", flash_ce_n, 1'b1);
        check_bit("sram_ce_n", sram_ce_n, 1'b1);
        check_bit("mem_we_n", mem_we_n, 1'b1);
        check_bit("data_oe", data_oe, 1'b0);
        check_bit("flash_reset_n", flash_reset_n, 1'b0);
        @(posedge arst_n);
        waited = 0;
        do begin
            @(posedge clock);
            @(negedge clock);
            waited++;
        end while (flash_reset_n !== 1'b1 && waited < wait_limit);
        check_len("flash_reset_n release clocks", waited, ref_hold_clocks());
        end_test("reset and power-up hold");

        // divider taps with a half period of 2^sel clocks
        for (i = 0; i < 4; i++) begin
            r = rand32();
            @(posedge clock);
            pclk_sel <= r[2:0];
            gclk_sel <= r[6:4];
            @(posedge clock);
            measure_half(1'b0, half);
            check_len("pixel_clock half period", half, 1 << r[2:0]);
            measure_half(1'b1, half);
            check_len("grayscale_clock half period", half, 1 << r[6:4]);
        end
        end_test("pixel and grayscale clocks");

        // sram write then read back the same byte
        for (i = 0; i < 6; i++) begin
            r = rand32();
            run_cycle(1'b0, 1'b1, 1'b1, r[15:0], r[20:16], r[31:24], rd);
            run_cycle(1'b0, 1'b1, 1'b0, r[15:0], r[20:16], 8'h00, rd);
            check_data("rd_data", rd, r[31:24]);
        end
        end_test("sram write and read");

        // flash write, read it back, read an unwritten spot
        for (i = 0; i < 6; i++) begin
            r = rand32();
            run_cycle(1'b1, 1'b0, 1'b1, r[15:0], r[20:16], r[31:24], rd);
            run_cycle(1'b1, 1'b0, 1'b0, r[15:0], r[20:16], 8'h00, rd);
            check_data("rd_data", rd, flash_byte(ref_addr(nx4_pkg::mem_flash, r[15:0], r[20:16])));
            r = rand32();
            run_cycle(1'b1, 1'b0, 1'b0, r[15:0], r[20:16], 8'h00, rd);
            check_data("rd_data", rd, flash_byte(ref_addr(nx4_pkg::mem_flash, r[15:0], r[20:16])));
        end
        end_test("flash write and read");

        // flash wins a tie and then i2c pull-downs and status packing
        r = rand32();
        run_cycle(1'b1, 1'b1, r[0], r[15:0], r[20:16], r[31:24], rd);
        for (i = 0; i < 6; i++) begin
            r = rand32();
            @(posedge clock);
            i2c_sda_ctl <= r[0];
            i2c_scl_ctl <= r[1];
            i2c_sda_in <= r[2];
            cpld_pins <= r[11:3];
            flash_ry_by <= r[12];
            led_xerr <= r[13];
            @(negedge clock);
            check_bit("i2c_sda_low", i2c_sda_low, ~r[0]);
            check_bit("i2c_scl_low", i2c_scl_low, ~r[1]);
            check_status("status", status, ref_status(r[11:3], r[12], r[13], r[2]));
        end
        end_test("strobe tie, i2c and status");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // budget of 2000 clocks per test
    initial begin
        repeat (num_tests * 2000) @(posedge clock);
        $display("watchdog expired after %0d clocks, run stopped", num_tests * 2000);
        $display("Regression failed");
        $finish;
    end

endmodule

/* nx4_glue.f */
common/nx4_pkg.sv
hdl/nx4_board_ctl.sv
mem_bitbang/mem_cycle_sequencer.sv
hdl/nx4_top.sv
sim/tb_clock_gen.sv
sim/tb_nx4_top.sv

/* Makefile */
# Verilator build and run of the nx4 glue testbench

TOP := tb_nx4_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f nx4_glue.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Regression passed" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
